// File: src/conv_params.svh
`ifndef CONV_PARAMS_SVH
`define CONV_PARAMS_SVH

// Sample and accumulator widths
`define SAMPLE_WIDTH 16
`define ACC_WIDTH 40

// Largest row or column count, and the width that holds it
`define MAX_DIM 16
`define DIM_WIDTH 5

// Top memory address bit selects data (1) or filter (0)
`define MEM_ADDR_WIDTH 9

// Host bus address width
`define HOST_ADDR_WIDTH 16

`endif

// File: src/convPkg.sv
`include "conv_params.svh"

package convPkg;

    // One memory word
    typedef logic signed [`SAMPLE_WIDTH-1:0] sampleT;

    // Running sum and result
    typedef logic signed [`ACC_WIDTH-1:0] accT;

    // Dimension inputs and loop counters
    typedef logic [`DIM_WIDTH-1:0] dimT;

    // Sample memory address
    typedef logic [`MEM_ADDR_WIDTH-1:0] memAddrT;

endpackage

// File: src/memPortIf.sv
`timescale 1ns/1ns

interface memPortIf import convPkg::*; ();

    // Requester side
    logic    req;
    memAddrT addr;
    logic    wrEn;
    sampleT  wrData;

    // Memory side
    logic    gnt;
    sampleT  rdData;
    logic    rdValid;

    // Fields stay steady until gnt; read data follows a grant by one cycle
    modport requester (
        output req, addr, wrEn, wrData,
        input  gnt, rdData, rdValid
    );

    modport arbiter (
        input  req, addr, wrEn, wrData,
        output gnt, rdData, rdValid
    );

endinterface

// File: src/hostWriter.sv
`timescale 1ns/1ns
`include "conv_params.svh"

module hostWriter import convPkg::*; (
    input  logic                        clkIn,
    input  logic                        rstIn,
    input  logic                        wrStrobeIn,
    input  logic [`HOST_ADDR_WIDTH-1:0] wrAddrIn,
    input  sampleT                      wrDataIn,
    memPortIf.requester                 memPort
);

    logic    inRange;
    logic    reqR;
    memAddrT addrR;
    sampleT  dataR;

    // Anything above the sample memory is dropped
    assign inRange = (wrAddrIn[`HOST_ADDR_WIDTH-1:`MEM_ADDR_WIDTH] == '0);

    always_ff @(posedge clkIn) begin
        if (rstIn) begin
            reqR <= 1'b0;
        end else begin
            reqR <= wrStrobeIn && inRange;
        end
    end

    // Host bit 8 maps straight onto the region bit
    always_ff @(posedge clkIn) begin
        addrR <= memAddrT'(wrAddrIn[`MEM_ADDR_WIDTH-1:0]);
        dataR <= wrDataIn;
    end

    // Host port has top priority and is granted in the cycle it requests
    assign memPort.req    = reqR;
    assign memPort.addr   = addrR;
    assign memPort.wrEn   = 1'b1;
    assign memPort.wrData = dataR;

endmodule

// File: src/convAddrGen.sv
`timescale 1ns/1ns
`include "conv_params.svh"

module convAddrGen import convPkg::*; (
    input  logic        clkIn,
    input  logic        rstIn,
    input  logic        startIn,
    input  dimT         filtRowsIn,
    input  dimT         filtColsIn,
    input  dimT         dataRowsIn,
    input  dimT         dataColsIn,
    output logic        busyOut,
    memPortIf.requester readPort,
    output logic        sampleValidOut,
    output logic        sampleIsFiltOut,
    output sampleT      sampleOut,
    output logic        lastTapOut
);

    typedef enum logic [1:0] {IDLE, RUN, WAIT_RES} stateT;

    stateT   stateR;
    logic    phaseR;
    logic    drainR;
    logic    dimsLegal;
    dimT     fColR, fRowR, oColR, oRowR;
    dimT     maxFiltColR, maxFiltRowR, maxOutColR, maxOutRowR;
    dimT     filtColsR, dataColsR;
    logic    lastTap, finalTap;
    memAddrT dataIdx, filtIdx;
    logic    pendFiltR, pendLastR;

    // Data dims are nonzero whenever the filter fits inside them
    assign dimsLegal = (filtRowsIn != '0) && (filtColsIn != '0)
        && (dataRowsIn <= dimT'(`MAX_DIM)) && (dataColsIn <= dimT'(`MAX_DIM))
        && (filtRowsIn <= dataRowsIn) && (filtColsIn <= dataColsIn);

    assign lastTap  = (fColR == maxFiltColR) && (fRowR == maxFiltRowR);
    assign finalTap = lastTap && (oColR == maxOutColR) && (oRowR == maxOutRowR);

    // Row-major offsets within each half of the memory
    assign dataIdx = memAddrT'(oRowR + fRowR) * memAddrT'(dataColsR)
        + memAddrT'(oColR) + memAddrT'(fColR);
    assign filtIdx = memAddrT'(fRowR) * memAddrT'(filtColsR) + memAddrT'(fColR);

    // Phase 0 reads the data sample, phase 1 the filter sample
    assign readPort.req    = (stateR == RUN);
    assign readPort.addr   = phaseR ? {1'b0, filtIdx[`MEM_ADDR_WIDTH-2:0]}
                                    : {1'b1, dataIdx[`MEM_ADDR_WIDTH-2:0]};
    assign readPort.wrEn   = 1'b0;
    assign readPort.wrData = '0;

    assign busyOut = (stateR != IDLE);

    always_ff @(posedge clkIn) begin
        if (rstIn) begin
            stateR <= IDLE;
            phaseR <= 1'b0;
            drainR <= 1'b0;
            fColR  <= '0;
            fRowR  <= '0;
            oColR  <= '0;
            oRowR  <= '0;
        end else begin
            case (stateR)
                IDLE: begin
                    phaseR <= 1'b0;
                    drainR <= 1'b0;
                    if (startIn && dimsLegal) begin
                        stateR <= RUN;
                        fColR  <= '0;
                        fRowR  <= '0;
                        oColR  <= '0;
                        oRowR  <= '0;
                    end
                end
                RUN: begin
                    if (readPort.gnt && !phaseR) begin
                        phaseR <= 1'b1;
                    end else if (readPort.gnt) begin
                        phaseR <= 1'b0;
                        if (finalTap) begin
                            stateR <= WAIT_RES;
                        end
                        // Filter column innermost, output row outermost
                        if (fColR != maxFiltColR) begin
                            fColR <= fColR + dimT'(1);
                        end else begin
                            fColR <= '0;
                            if (fRowR != maxFiltRowR) begin
                                fRowR <= fRowR + dimT'(1);
                            end else begin
                                fRowR <= '0;
                                if (oColR != maxOutColR) begin
                                    oColR <= oColR + dimT'(1);
                                end else begin
                                    oColR <= '0;
                                    oRowR <= oRowR + dimT'(1);
                                end
                            end
                        end
                    end
                end
                WAIT_RES: begin
                    // Last sample lands, then the result strobe, then done
                    drainR <= 1'b1;
                    if (drainR) begin
                        stateR <= IDLE;
                    end
                end
                default: stateR <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clkIn) begin
        if (stateR == IDLE && startIn) begin
            filtColsR   <= filtColsIn;
            dataColsR   <= dataColsIn;
            maxFiltColR <= filtColsIn - dimT'(1);
            maxFiltRowR <= filtRowsIn - dimT'(1);
            maxOutColR  <= dataColsIn - filtColsIn;
            maxOutRowR  <= dataRowsIn - filtRowsIn;
        end
        // Tag travels with the granted read to match its returning data
        if (readPort.gnt) begin
            pendFiltR <= phaseR;
            pendLastR <= phaseR && lastTap;
        end
    end

    assign sampleValidOut  = readPort.rdValid;
    assign sampleIsFiltOut = pendFiltR;
    assign sampleOut       = readPort.rdData;
    assign lastTapOut      = pendLastR;

endmodule

// File: src/sampleMem.sv
`timescale 1ns/1ns
`include "conv_params.svh"

module sampleMem import convPkg::*; (
    input  logic      clkIn,
    input  logic      rstIn,
    memPortIf.arbiter hostPort,
    memPortIf.arbiter readPort
);

    sampleT  memArray [0:(1 << `MEM_ADDR_WIDTH)-1];
    memAddrT selAddr;
    logic    selWrEn;
    sampleT  selWrData;
    logic    anyGnt;
    sampleT  rdDataR;
    logic    hostRdValidR;
    logic    readRdValidR;

    // Host always wins over the reader
    assign hostPort.gnt = hostPort.req;
    assign readPort.gnt = readPort.req && !hostPort.req;
    assign anyGnt       = hostPort.req || readPort.req;

    // The winner's fields drive the single array port
    assign selAddr   = hostPort.req ? hostPort.addr   : readPort.addr;
    assign selWrEn   = hostPort.req ? hostPort.wrEn   : readPort.wrEn;
    assign selWrData = hostPort.req ? hostPort.wrData : readPort.wrData;

    always_ff @(posedge clkIn) begin
        if (anyGnt && selWrEn) begin
            memArray[selAddr] <= selWrData;
        end
        rdDataR <= memArray[selAddr];
    end

    always_ff @(posedge clkIn) begin
        if (rstIn) begin
            hostRdValidR <= 1'b0;
            readRdValidR <= 1'b0;
        end else begin
            hostRdValidR <= hostPort.gnt && !hostPort.wrEn;
            readRdValidR <= readPort.gnt && !readPort.wrEn;
        end
    end

    assign hostPort.rdData  = rdDataR;
    assign hostPort.rdValid = hostRdValidR;
    assign readPort.rdData  = rdDataR;
    assign readPort.rdValid = readRdValidR;

endmodule

// File: src/macUnit.sv
`timescale 1ns/1ns

module macUnit import convPkg::*; (
    input  logic   clkIn,
    input  logic   rstIn,
    input  logic   sampleValidIn,
    input  logic   sampleIsFiltIn,
    input  logic   lastTapIn,
    input  sampleT sampleIn,
    output logic   resultValidOut,
    output accT    resultOut
);

    sampleT dataR;
    accT    accR;
    accT    product;
    accT    sumNext;
    logic   filtValid;

    assign filtValid = sampleValidIn && sampleIsFiltIn;

    // Operands widened first so the product keeps its sign
    assign product = accT'(dataR) * accT'(sampleIn);
    assign sumNext = accR + product;

    always_ff @(posedge clkIn) begin
        if (rstIn) begin
            accR           <= '0;
            resultValidOut <= 1'b0;
        end else begin
            resultValidOut <= filtValid && lastTapIn;
            if (filtValid) begin
                // Restart from zero after each output position
                accR <= lastTapIn ? '0 : sumNext;
            end
        end
    end

    always_ff @(posedge clkIn) begin
        if (sampleValidIn && !sampleIsFiltIn) begin
            dataR <= sampleIn;
        end
        if (filtValid && lastTapIn) begin
            resultOut <= sumNext;
        end
    end

endmodule

// File: src/convAccel.sv
`timescale 1ns/1ns
`include "conv_params.svh"

module convAccel (
    input  logic                        clkIn,
    input  logic                        rstIn,
    input  logic                        wrStrobeIn,
    input  logic [`HOST_ADDR_WIDTH-1:0] wrAddrIn,
    input  logic [`SAMPLE_WIDTH-1:0]    wrDataIn,
    input  logic                        startIn,
    input  logic [`DIM_WIDTH-1:0]       filtRowsIn,
    input  logic [`DIM_WIDTH-1:0]       filtColsIn,
    input  logic [`DIM_WIDTH-1:0]       dataRowsIn,
    input  logic [`DIM_WIDTH-1:0]       dataColsIn,
    output logic                        busyOut,
    output logic                        resultValidOut,
    output logic [`ACC_WIDTH-1:0]       resultOut
);

    // Sample stream from address generator to MAC
    logic                     sampleValid;
    logic                     sampleIsFilt;
    logic                     lastTap;
    logic [`SAMPLE_WIDTH-1:0] sample;

    memPortIf hostPort ();
    memPortIf readPort ();

    hostWriter hostWriterInst (
        .clkIn      (clkIn),
        .rstIn      (rstIn),
        .wrStrobeIn (wrStrobeIn),
        .wrAddrIn   (wrAddrIn),
        .wrDataIn   (wrDataIn),
        .memPort    (hostPort)
    );

    convAddrGen addrGenInst (
        .clkIn           (clkIn),
        .rstIn           (rstIn),
        .startIn         (startIn),
        .filtRowsIn      (filtRowsIn),
        .filtColsIn      (filtColsIn),
        .dataRowsIn      (dataRowsIn),
        .dataColsIn      (dataColsIn),
        .busyOut         (busyOut),
        .readPort        (readPort),
        .sampleValidOut  (sampleValid),
        .sampleIsFiltOut (sampleIsFilt),
        .sampleOut       (sample),
        .lastTapOut      (lastTap)
    );

    sampleMem sampleMemInst (
        .clkIn    (clkIn),
        .rstIn    (rstIn),
        .hostPort (hostPort),
        .readPort (readPort)
    );

    macUnit macInst (
        .clkIn          (clkIn),
        .rstIn          (rstIn),
        .sampleValidIn  (sampleValid),
        .sampleIsFiltIn (sampleIsFilt),
        .lastTapIn      (lastTap),
        .sampleIn       (sample),
        .resultValidOut (resultValidOut),
        .resultOut      (resultOut)
    );

endmodule

// File: verif/convAccel_chk.sv
`timescale 1ns/1ns
`include "conv_params.svh"

module convAccelChk (
    input logic                       clkIn,
    input logic                       rstIn,
    input logic                       startIn,
    input logic [`DIM_WIDTH-1:0]      filtRowsIn,
    input logic [`DIM_WIDTH-1:0]      filtColsIn,
    input logic [`DIM_WIDTH-1:0]      dataRowsIn,
    input logic [`DIM_WIDTH-1:0]      dataColsIn,
    input logic                       busyOut,
    input logic                       resultValidOut,
    input logic                       readReq,
    input logic [`MEM_ADDR_WIDTH-1:0] readAddr,
    input logic                       readGnt,
    input logic                       hostGnt
);

    logic startIllegal;

    // One failure count per assertion
    int resultBusyFails = 0;
    int resetFails = 0;
    int readHoldFails = 0;
    int grantFails = 0;
    int illegalStartFails = 0;

    // Zero or oversized dimension, or a filter that does not fit
    assign startIllegal = (filtRowsIn == '0) || (filtColsIn == '0)
        || (dataRowsIn == '0) || (dataColsIn == '0)
        || (dataRowsIn > `DIM_WIDTH'(`MAX_DIM)) || (dataColsIn > `DIM_WIDTH'(`MAX_DIM))
        || (filtRowsIn > dataRowsIn) || (filtColsIn > dataColsIn);

    assert property (@(posedge clkIn) disable iff (rstIn) resultValidOut |-> busyOut)
        else begin
            $error("Result strobe while the accelerator is idle");
            resultBusyFails = resultBusyFails + 1;
        end

    assert property (@(posedge clkIn) rstIn |=> (!busyOut && !resultValidOut))
        else begin
            $error("Busy or result strobe high right after reset");
            resetFails = resetFails + 1;
        end

    // Read request held with a steady address until granted
    assert property (@(posedge clkIn) disable iff (rstIn)
        (readReq && !readGnt) |=> (readReq && $stable(readAddr)))
        else begin
            $error("Read request dropped or changed before grant");
            readHoldFails = readHoldFails + 1;
        end

    assert property (@(posedge clkIn) disable iff (rstIn) !(hostGnt && readGnt))
        else begin
            $error("Host and read port granted in the same cycle");
            grantFails = grantFails + 1;
        end

    assert property (@(posedge clkIn) disable iff (rstIn)
        (startIn && !busyOut && startIllegal) |=> !busyOut)
        else begin
            $error("Illegal start raised busy");
            illegalStartFails = illegalStartFails + 1;
        end

endmodule

bind convAccel convAccelChk chkInst (
    .clkIn          (clkIn),
    .rstIn          (rstIn),
    .startIn        (startIn),
    .filtRowsIn     (filtRowsIn),
    .filtColsIn     (filtColsIn),
    .dataRowsIn     (dataRowsIn),
    .dataColsIn     (dataColsIn),
    .busyOut        (busyOut),
    .resultValidOut (resultValidOut),
    .readReq        (readPort.req),
    .readAddr       (readPort.addr),
    .readGnt        (readPort.gnt),
    .hostGnt        (hostPort.gnt)
);

// File: verif/convAccelTb.sv
`timescale 1ns/1ns
`include "conv_params.svh"

module convAccelTb import convPkg::*; ();

    localparam int DATA_BASE = 1 << (`MEM_ADDR_WIDTH - 1);
    // Three runs of the 5x6 by 3x2 case plus the two full-size runs
    localparam int SMALL_TAPS = (5 - 3 + 1) * (6 - 2 + 1) * 3 * 2;
    localparam int TAP_TOTAL = 3 * SMALL_TAPS + 16 * 16 + 16 * 16;
    localparam int LOAD_CYCLES = 36 + 16 + 3 + 257 + 256 + 200;
    localparam int CYCLE_LIMIT = TAP_TOTAL * 6 + LOAD_CYCLES;

    logic                        clkIn;
    logic                        rstIn;
    logic                        wrStrobeIn;
    logic [`HOST_ADDR_WIDTH-1:0] wrAddrIn;
    logic [`SAMPLE_WIDTH-1:0]    wrDataIn;
    logic                        startIn;
    logic [`DIM_WIDTH-1:0]       filtRowsIn;
    logic [`DIM_WIDTH-1:0]       filtColsIn;
    logic [`DIM_WIDTH-1:0]       dataRowsIn;
    logic [`DIM_WIDTH-1:0]       dataColsIn;
    logic                        busyOut;
    logic                        resultValidOut;
    logic [`ACC_WIDTH-1:0]       resultOut;

    // Testbench copy of the sample memory
    sampleT      model [0:(1 << `MEM_ADDR_WIDTH)-1];
    accT         expQ [$];
    accT         expVal;
    string       curTest;
    logic [31:0] lfsrState = 32'd83502;
    int          valueErrors = 0;
    int          otherErrors = 0;
    int          cycleCount = 0;

    convAccel dut (.*);

    always #5 clkIn = ~clkIn;

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // Eight LFSR steps give one sign-extended 8-bit sample
    task automatic drawSample(output sampleT s);
        logic [7:0] b;
        b = '0;
        for (int k = 0; k < 8; k++) begin
            lfsrState = lfsrStep(lfsrState);
            b = {b[6:0], lfsrState[0]};
        end
        s = {{(`SAMPLE_WIDTH - 8){b[7]}}, b};
    endtask

    function automatic accT refValue(input int fr, input int fc, input int dc,
                                     input int r, input int c);
        accT sum;
        sum = '0;
        for (int i = 0; i < fr; i++) begin
            for (int j = 0; j < fc; j++) begin
                sum += accT'(model[DATA_BASE + (r + i) * dc + c + j]) * accT'(model[i * fc + j]);
            end
        end
        return sum;
    endfunction

    task automatic hostWrite(input logic [`HOST_ADDR_WIDTH-1:0] addr, input sampleT data);
        @(posedge clkIn);
        wrStrobeIn <= 1'b1;
        wrAddrIn   <= addr;
        wrDataIn   <= data;
        // Out-of-range writes never reach memory
        if (addr < `HOST_ADDR_WIDTH'(1 << `MEM_ADDR_WIDTH)) begin
            model[addr[`MEM_ADDR_WIDTH-1:0]] = data;
        end
    endtask

    task automatic writeDone();
        @(posedge clkIn);
        wrStrobeIn <= 1'b0;
    endtask

    task automatic loadRegion(input int base, input int count);
        sampleT s;
        for (int k = 0; k < count; k++) begin
            drawSample(s);
            hostWrite(`HOST_ADDR_WIDTH'(base + k), s);
        end
        writeDone();
    endtask

    task automatic runConv(input string name, input int fr, input int fc,
                           input int dr, input int dc);
        curTest = name;
        for (int r = 0; r <= dr - fr; r++) begin
            for (int c = 0; c <= dc - fc; c++) begin
                expQ.push_back(refValue(fr, fc, dc, r, c));
            end
        end
        @(posedge clkIn);
        filtRowsIn <= dimT'(fr);
        filtColsIn <= dimT'(fc);
        dataRowsIn <= dimT'(dr);
        dataColsIn <= dimT'(dc);
        startIn    <= 1'b1;
        @(posedge clkIn);
        startIn <= 1'b0;
        @(negedge clkIn);
        assert (busyOut) else begin
            $display("Run %s did not start, busy stayed low", name);
            otherErrors++;
        end
        while (busyOut) @(negedge clkIn);
        assert (expQ.size() == 0) else begin
            $display("Run %s ended with %0d results missing", name, expQ.size());
            otherErrors++;
            expQ.delete();
        end
    endtask

    task automatic illegalStart(input string name, input int fr, input int fc,
                                input int dr, input int dc);
        @(posedge clkIn);
        filtRowsIn <= dimT'(fr);
        filtColsIn <= dimT'(fc);
        dataRowsIn <= dimT'(dr);
        dataColsIn <= dimT'(dc);
        startIn    <= 1'b1;
        @(posedge clkIn);
        startIn <= 1'b0;
        repeat (2) begin
            @(negedge clkIn);
            assert (!busyOut) else begin
                $display("Start %s was accepted although illegal", name);
                otherErrors++;
            end
        end
    endtask

    // Results compared in raster order
    always @(negedge clkIn) begin
        if (resultValidOut) begin
            if (expQ.size() == 0) begin
                $display("Unexpected result %0d in %s", $signed(resultOut), curTest);
                otherErrors++;
            end else begin
                expVal = expQ.pop_front();
                assert (resultOut == expVal) else begin
                    $display("Fail %s: expected %0d, actual %0d",
                             curTest, expVal, $signed(resultOut));
                    valueErrors++;
                end
            end
        end
    end

    always @(posedge clkIn) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, the DUT did not finish", CYCLE_LIMIT);
            $display("Test failures found");
            $finish;
        end
    end

    initial begin
        sampleT s;
        int     chkErrors;
        clkIn      = 1'b0;
        rstIn      = 1'b1;
        wrStrobeIn = 1'b0;
        wrAddrIn   = '0;
        wrDataIn   = '0;
        startIn    = 1'b0;
        filtRowsIn = '0;
        filtColsIn = '0;
        dataRowsIn = '0;
        dataColsIn = '0;
        repeat (10) @(posedge clkIn);
        rstIn <= 1'b0;

        loadRegion(DATA_BASE, 5 * 6);
        loadRegion(0, 3 * 2);
        runConv("small 5x6 by 3x2", 3, 2, 5, 6);

        // Host traffic to unused cells stalls the reader mid-run
        fork
            runConv("writes during run", 3, 2, 5, 6);
            begin
                repeat (6) @(posedge clkIn);
                for (int k = 0; k < 8; k++) begin
                    drawSample(s);
                    hostWrite(`HOST_ADDR_WIDTH'(DATA_BASE + 64 + k), s);
                    drawSample(s);
                    hostWrite(`HOST_ADDR_WIDTH'(100 + k), s);
                end
                writeDone();
            end
        join

        // These would alias onto live filter and data cells
        hostWrite(16'h0200, 16'sh7abc);
        hostWrite(16'h0301, 16'sh7abc);
        hostWrite(16'hff05, -16'sd1234);
        writeDone();
        runConv("after dropped writes", 3, 2, 5, 6);

        illegalStart("filter taller than data", 6, 2, 5, 6);
        illegalStart("filter wider than data", 3, 7, 5, 6);
        illegalStart("zero filter rows", 0, 2, 5, 6);
        illegalStart("zero data columns", 1, 1, 5, 0);
        illegalStart("data rows above maximum", 1, 1, 17, 4);

        loadRegion(DATA_BASE, 16 * 16);
        loadRegion(0, 1);
        runConv("16x16 by 1x1", 1, 1, 16, 16);
        loadRegion(0, 16 * 16);
        runConv("16x16 by 16x16", 16, 16, 16, 16);
        repeat (5) @(posedge clkIn);

        chkErrors = dut.chkInst.resultBusyFails + dut.chkInst.resetFails
            + dut.chkInst.readHoldFails + dut.chkInst.grantFails
            + dut.chkInst.illegalStartFails;
        $display("Errors: %0d value, %0d other, %0d protocol",
                 valueErrors, otherErrors, chkErrors);
        if (valueErrors + otherErrors + chkErrors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: src.f
+incdir+src
src/convPkg.sv
src/memPortIf.sv
src/hostWriter.sv
src/convAddrGen.sv
src/sampleMem.sv
src/macUnit.sv
src/convAccel.sv
verif/convAccel_chk.sv
verif/convAccelTb.sv

// File: run.sh
#!/bin/sh
# Build and run the convolution accelerator testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f src.f --top-module convAccelTb \
    -Mdir obj_dir -o convAccelSim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/convAccelSim +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test failures found" "$LOG"; then
    echo "FAIL"
    exit 1
fi
echo "PASS"
exit 0
